// File: tb.f
src/isaPkg.sv
src/memPkg.sv
src/agen.sv
src/loadUnit.sv
src/storeUnit.sv
src/memArbiter.sv
src/dataMem.sv
src/memSubsys.sv
verif/memSubsys_properties.sv
verif/memSubsys_tb.sv

// File: verif/memSubsys_tb.sv
// Memory stage testbench
`timescale 1ns/1ps
`default_nettype none

module memSubsys_tb
	import isaPkg::*, memPkg::*;
();

	typedef enum logic [2:0] {kLoad, kStore, kBoth, kStoreLoad, kBusy} kindT;

	// one table row, the operand c is shared by the load and the store
	typedef struct packed {
		kindT kind;
		logic randC;
		instT stInst;
		wordT stA;
		instT ldInst;
		wordT ldA;
	} testT;

	logic clk;
	logic rst;
	logic ldGo;
	instT ldInst;
	wordT ldA;
	wordT ldC;
	logic stGo;
	instT stInst;
	wordT stA;
	wordT stB;
	wordT stC;
	logic ldBusy;
	logic stBusy;
	logic ldValid;
	wordT ldData;
	logic stDone;

	testT tests[$];
	string names[$];
	wordT model [64];
	logic [31:0] lfsr = 32'h4eb8;
	int errors = 0;
	int passed = 0;
	int cycleCount = 0;
	int limit = 1000;

	memSubsys #(.DEPTH(64)) dut0 (
		.clk(clk), .rst(rst), .ldGo(ldGo), .ldInst(ldInst), .ldA(ldA), .ldC(ldC),
		.stGo(stGo), .stInst(stInst), .stA(stA), .stB(stB), .stC(stC),
		.ldBusy(ldBusy), .stBusy(stBusy), .ldValid(ldValid), .ldData(ldData),
		.stDone(stDone)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	// the run is cut off if the table takes longer than its cycle budget
	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= limit) begin
			$display("timeout: no result after %0d cycles, the DUT stopped responding", limit);
			$display("tests failed");
			$finish;
		end
	end

	// ==============================
	// stimulus helpers
	// ==============================

	// 32-bit Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic drawBits(input int n, output wordT w);
		int i;
		w = '0;
		for (i = 0; i < n; i++) begin
			w = {w[78:0], lfsr[31]};
			lfsr = lfsrNext(lfsr);
		end
	endtask

	// displacement is 22 bits, split over bits 39..33 and 30..16
	function automatic instT mkDisp(input opcodeT op, input logic [21:0] d);
		instT i;
		i = '0;
		i[3:0] = op;
		i[39:33] = d[21:15];
		i[30:16] = d[14:0];
		return i;
	endfunction

	// the 8-bit offset sits in bits 34..33 and 21..16, scale in 30..28
	function automatic instT mkIdx(input opcodeT op, input logic [2:0] sc, input logic [7:0] ofs);
		instT i;
		i = '0;
		i[3:0] = op;
		i[30:28] = sc;
		i[34:33] = ofs[7:6];
		i[21:16] = ofs[5:0];
		return i;
	endfunction

	// expected slot from the address rules of the memory stage
	function automatic slotT refSlot(input logic isStore, input instT inst, input wordT a,
			input wordT c);
		opcodeT op;
		logic [21:0] d;
		wordT mult;
		wordT addr;
		op = inst[3:0];
		d = {inst[39:33], inst[30:16]};
		case (inst[30:28])
			3'd0: mult = 1;
			3'd1: mult = 2;
			3'd2: mult = 4;
			3'd3: mult = 8;
			3'd4: mult = 16;
			3'd5: mult = 5;
			3'd6: mult = 10;
			default: mult = 15;
		endcase
		if ((!isStore && op == opMLX) || (isStore && op == opMSX)) begin
			addr = a + c * mult + wordT'({inst[34:33], inst[21:16]});
		end else if (isStore && (op == opPUSH || op == opPUSHC)) begin
			addr = a - 80'd10;
		end else begin
			addr = a + {{58{d[21]}}, d};
		end
		return addr[5:0];
	endfunction

	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	// ==============================
	// compare tasks
	// ==============================

	task automatic checkWord(input string name, input wordT exp, input wordT act);
		if (act !== exp) begin
			$display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic checkBit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("CHECK FAILED t=%0t %s expected %b actual %b", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic checkCycles(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("CHECK FAILED t=%0t %s expected %0d actual %0d", $time, name, exp, act);
			errors++;
		end
	endtask

	// ==============================
	// operations
	// ==============================

	task automatic doStore(input instT inst, input wordT a, input wordT b, input wordT c,
			output int cyc);
		slotT s;
		s = refSlot(1'b1, inst, a, c);
		stInst = inst;
		stA = a;
		stB = b;
		stC = c;
		stGo = 1'b1;
		cyc = 0;
		do begin
			tick();
			stGo = 1'b0;
			cyc++;
		end while (!stDone);
		model[s] = b;
		checkWord($sformatf("mem[%0d]", s), b, dut0.mem0.mem[s]);
	endtask

	task automatic doLoad(input instT inst, input wordT a, input wordT c, output int cyc);
		slotT s;
		s = refSlot(1'b0, inst, a, c);
		ldInst = inst;
		ldA = a;
		ldC = c;
		ldGo = 1'b1;
		cyc = 0;
		do begin
			tick();
			ldGo = 1'b0;
			cyc++;
		end while (!ldValid);
		checkWord("ldData", model[s], ldData);
	endtask

	// both units issue together, the loser of the arbitration finishes one cycle later
	task automatic doBoth(input testT t, input wordT b);
		slotT ls;
		slotT ss;
		int cyc;
		int ldAt;
		int stAt;
		ls = refSlot(1'b0, t.ldInst, t.ldA, '0);
		ss = refSlot(1'b1, t.stInst, t.stA, '0);
		ldInst = t.ldInst;
		ldA = t.ldA;
		ldC = '0;
		stInst = t.stInst;
		stA = t.stA;
		stB = b;
		stC = '0;
		ldGo = 1'b1;
		stGo = 1'b1;
		cyc = 0;
		ldAt = 0;
		stAt = 0;
		while (ldAt == 0 || stAt == 0) begin
			tick();
			ldGo = 1'b0;
			stGo = 1'b0;
			cyc++;
			if (ldValid) begin
				ldAt = cyc;
				checkWord("ldData", model[ls], ldData);
			end
			if (stDone) begin
				stAt = cyc;
			end
		end
		model[ss] = b;
		checkWord($sformatf("mem[%0d]", ss), b, dut0.mem0.mem[ss]);
		checkCycles("first completion", 2, (ldAt < stAt) ? ldAt : stAt);
		checkCycles("second completion", 3, (ldAt < stAt) ? stAt : ldAt);
	endtask

	// a second stGo while busy must leave no trace
	task automatic doBusy(input testT t, input wordT b);
		slotT s;
		wordT b2;
		int pulses;
		int i;
		s = refSlot(1'b1, t.stInst, t.stA, '0);
		drawBits(80, b2);
		stInst = t.stInst;
		stA = t.stA;
		stB = b;
		stC = '0;
		stGo = 1'b1;
		tick();
		checkBit("stBusy", 1'b1, stBusy);
		stB = b2;
		pulses = 0;
		for (i = 0; i < 6; i++) begin
			tick();
			stGo = 1'b0;
			if (stDone) begin
				pulses++;
			end
		end
		checkCycles("stDone pulses", 1, pulses);
		model[s] = b;
		checkWord($sformatf("mem[%0d]", s), b, dut0.mem0.mem[s]);
	endtask

	task automatic runTest(input int idx);
		testT t;
		wordT b;
		wordT c;
		int cyc;
		int errBefore;
		t = tests[idx];
		errBefore = errors;
		c = '0;
		if (t.randC) begin
			drawBits(8, c);
		end
		drawBits(80, b);
		case (t.kind)
			kStore: begin
				doStore(t.stInst, t.stA, b, c, cyc);
				checkCycles("stGo to stDone", 2, cyc);
			end
			kLoad: begin
				doLoad(t.ldInst, t.ldA, c, cyc);
				checkCycles("ldGo to ldValid", 2, cyc);
			end
			kStoreLoad: begin
				doStore(t.stInst, t.stA, b, c, cyc);
				checkCycles("stGo to stDone", 2, cyc);
				doLoad(t.ldInst, t.ldA, c, cyc);
				checkCycles("ldGo to ldValid", 2, cyc);
			end
			kBoth: doBoth(t, b);
			default: doBusy(t, b);
		endcase
		// both units are idle again one cycle after their last pulse
		tick();
		checkBit("ldBusy", 1'b0, ldBusy);
		checkBit("stBusy", 1'b0, stBusy);
		if (errors == errBefore) begin
			passed++;
			$display("test %0d %s: ok", idx, names[idx]);
		end else begin
			$display("test %0d %s: FAILED", idx, names[idx]);
		end
	endtask

	task automatic addTest(input string name, input kindT kind, input logic randC,
			input instT stI, input wordT stAv, input instT ldI, input wordT ldAv);
		testT t;
		t.kind = kind;
		t.randC = randC;
		t.stInst = stI;
		t.stA = stAv;
		t.ldInst = ldI;
		t.ldA = ldAv;
		tests.push_back(t);
		names.push_back(name);
	endtask

	// ==============================
	// test table and main sequence
	// ==============================

	initial begin
		int s;
		int i;
		ldGo = 1'b0;
		ldInst = '0;
		ldA = '0;
		ldC = '0;
		stGo = 1'b0;
		stInst = '0;
		stA = '0;
		stB = '0;
		stC = '0;
		rst = 1'b1;
		addTest("disp store and load", kStoreLoad, 1'b0, mkDisp(opStore, 22'd12), 80'd100,
			mkDisp(opLoad, 22'd12), 80'd100);
		addTest("negative disp", kStoreLoad, 1'b0, mkDisp(opStore, -22'sd37), 80'd200,
			mkDisp(opLoad, 22'd3), 80'd160);
		addTest("lone store", kStore, 1'b0, mkDisp(opStore, 22'd5), 80'd0, '0, '0);
		// the base wraps around to reach slot 5 again
		addTest("lone load", kLoad, 1'b0, '0, '0, mkDisp(opLoad, 22'd6), {80{1'b1}});
		for (s = 0; s < 8; s++) begin
			addTest($sformatf("indexed scale %0d", s), kStoreLoad, 1'b1,
				mkIdx(opMSX, s[2:0], 8'(40 + s * 21)), wordT'(1000 + s * 7),
				mkIdx(opMLX, s[2:0], 8'(40 + s * 21)), wordT'(1000 + s * 7));
		end
		addTest("push", kStoreLoad, 1'b0, mkDisp(opPUSH, 22'd0), 80'd300,
			mkDisp(opLoad, -22'sd10), 80'd300);
		addTest("pushc", kStoreLoad, 1'b0, mkDisp(opPUSHC, 22'd0), 80'd77,
			mkDisp(opLoad, 22'd0), 80'd67);
		// a load was granted last, so the store wins this contention
		addTest("both together", kBoth, 1'b0, mkDisp(opStore, 22'd20), 80'd0,
			mkDisp(opLoad, 22'd3), 80'd0);
		addTest("go while busy", kBusy, 1'b0, mkDisp(opStore, 22'd30), 80'd0, '0, '0);
		// a store was granted last, so now the load wins and the store has to wait
		addTest("both again", kBoth, 1'b0, mkDisp(opStore, 22'd21), 80'd0,
			mkDisp(opLoad, 22'd20), 80'd0);
		limit = tests.size() * 12 + 10;
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;
		for (i = 0; i < tests.size(); i++) begin
			runTest(i);
		end
		$display("%0d of %0d tests ok, %0d check errors, %0d assertion failures", passed,
			tests.size(), errors, dut0.props0.failCount);
		if (errors == 0 && dut0.props0.failCount == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/memSubsys_properties.sv
// Arbiter and unit assertions
`timescale 1ns/1ps
`default_nettype none

module memSubsysProperties
	import memPkg::*;
(
	input wire clk,
	input wire rst,
	input wire memReqT ldReq,
	input wire memReqT stReq,
	input wire ldGrant,
	input wire stGrant,
	input wire ldValid,
	input wire stDone
);

	// number of assertion failures seen so far
	int failCount = 0;

	// ==============================
	// arbiter
	// ==============================

	// one memory port, so at most one grant per cycle
	oneGrant: assert property (@(posedge clk) disable iff (rst) !(ldGrant && stGrant))
		else begin
			$error("load and store granted in the same cycle");
			failCount++;
		end

	ldGrantValid: assert property (@(posedge clk) disable iff (rst) ldGrant |-> ldReq.valid)
		else begin
			$error("load grant without a load request");
			failCount++;
		end

	stGrantValid: assert property (@(posedge clk) disable iff (rst) stGrant |-> stReq.valid)
		else begin
			$error("store grant without a store request");
			failCount++;
		end

	// ==============================
	// units
	// ==============================

	// a waiting request must not change under the arbiter
	ldHold: assert property (@(posedge clk) disable iff (rst)
		ldReq.valid && !ldGrant |=> $stable(ldReq))
		else begin
			$error("load request changed before its grant");
			failCount++;
		end

	stHold: assert property (@(posedge clk) disable iff (rst)
		stReq.valid && !stGrant |=> $stable(stReq))
		else begin
			$error("store request changed before its grant");
			failCount++;
		end

	ldPulse: assert property (@(posedge clk) disable iff (rst) ldValid |=> !ldValid)
		else begin
			$error("ldValid longer than one cycle");
			failCount++;
		end

	stPulse: assert property (@(posedge clk) disable iff (rst) stDone |=> !stDone)
		else begin
			$error("stDone longer than one cycle");
			failCount++;
		end

endmodule

// the top level is where the arbiter and both units meet
bind memSubsys memSubsysProperties props0 (
	.clk(clk), .rst(rst), .ldReq(ldReq), .stReq(stReq), .ldGrant(ldGrant),
	.stGrant(stGrant), .ldValid(ldValid), .stDone(stDone)
);

`default_nettype wire

// File: src/memSubsys.sv
// Memory stage top level
`timescale 1ns/1ps
`default_nettype none

module memSubsys
	import isaPkg::*, memPkg::*;
#(
	parameter int DEPTH = 64
) (
	input wire clk,
	input wire rst,
	input wire ldGo,
	input wire instT ldInst,
	input wire wordT ldA,
	input wire wordT ldC,
	input wire stGo,
	input wire instT stInst,
	input wire wordT stA,
	input wire wordT stB,
	input wire wordT stC,
	output logic ldBusy,
	output logic stBusy,
	output logic ldValid,
	output wordT ldData,
	output logic stDone
);

	memReqT ldReq;
	memReqT stReq;
	memReqT memReq;
	memRspT memRsp;
	memRspT ldRsp;
	logic ldGrant;
	logic stGrant;

	// ==============================
	// units, arbiter and memory
	// ==============================

	loadUnit ldUnit0 (
		.clk(clk), .rst(rst), .go(ldGo), .inst(ldInst), .a(ldA), .c(ldC),
		.grant(ldGrant), .rsp(ldRsp), .req(ldReq), .busy(ldBusy),
		.valid(ldValid), .data(ldData)
	);

	storeUnit stUnit0 (
		.clk(clk), .rst(rst), .go(stGo), .inst(stInst), .a(stA), .b(stB), .c(stC),
		.grant(stGrant), .req(stReq), .busy(stBusy), .done(stDone)
	);

	memArbiter arb0 (
		.clk(clk), .rst(rst), .ldReq(ldReq), .stReq(stReq), .memRsp(memRsp),
		.ldGrant(ldGrant), .stGrant(stGrant), .memReq(memReq), .ldRsp(ldRsp)
	);

	// the depth is chosen here and passed down to the memory
	dataMem #(.DEPTH(DEPTH)) mem0 (
		.clk(clk), .rst(rst), .req(memReq), .rsp(memRsp)
	);

endmodule

`default_nettype wire

// File: src/dataMem.sv
// Single-port data memory
`timescale 1ns/1ps
`default_nettype none

module dataMem
	import isaPkg::*, memPkg::*;
#(
	parameter int DEPTH = 64
) (
	input wire clk,
	input wire rst,
	input wire memReqT req,
	output memRspT rsp
);

	localparam int idxBits = $clog2(DEPTH);

	wordT mem [DEPTH];
	logic [idxBits-1:0] idx;

	// a smaller memory simply ignores the upper slot bits
	assign idx = req.slot[idxBits-1:0];

	// ==============================
	// storage and read port
	// ==============================

	// contents are left alone by reset
	always_ff @(posedge clk) begin
		if (req.valid && req.write) begin
			mem[idx] <= req.data;
		end
		if (req.valid && !req.write) begin
			rsp.data <= mem[idx];
		end
	end

	// read data is valid for the one cycle after the read request
	always_ff @(posedge clk) begin
		if (rst) begin
			rsp.valid <= 1'b0;
		end else begin
			rsp.valid <= req.valid && !req.write;
		end
	end

endmodule

`default_nettype wire

// File: src/memArbiter.sv
// Round-robin memory arbiter
`timescale 1ns/1ps
`default_nettype none

module memArbiter
	import memPkg::*;
(
	input wire clk,
	input wire rst,
	input wire memReqT ldReq,
	input wire memReqT stReq,
	input wire memRspT memRsp,
	output logic ldGrant,
	output logic stGrant,
	output memReqT memReq,
	output memRspT ldRsp
);

	ownerT lastOwner;

	// ==============================
	// grant decision
	// ==============================

	// under contention the unit that did not win last time goes first
	// a lone request is granted at once
	assign ldGrant = ldReq.valid && (!stReq.valid || lastOwner == ownStore);
	assign stGrant = stReq.valid && !ldGrant;

	// reset to store so the first contended grant goes to the load unit
	always_ff @(posedge clk) begin
		if (rst) begin
			lastOwner <= ownStore;
		end else if (ldGrant) begin
			lastOwner <= ownLoad;
		end else if (stGrant) begin
			lastOwner <= ownStore;
		end
	end

	// the memory port sees exactly the granted request and nothing otherwise
	always_comb begin
		if (ldGrant) begin
			memReq = ldReq;
		end else if (stGrant) begin
			memReq = stReq;
		end else begin
			memReq = '0;
		end
	end

	// only loads read, so every response belongs to the load unit
	assign ldRsp = memRsp;

endmodule

`default_nettype wire

// File: src/storeUnit.sv
// Store unit
`timescale 1ns/1ps
`default_nettype none

module storeUnit
	import isaPkg::*, memPkg::*;
(
	input wire clk,
	input wire rst,
	input wire go,
	input wire instT inst,
	input wire wordT a,
	input wire wordT b,
	input wire wordT c,
	input wire grant,
	output memReqT req,
	output logic busy,
	output logic done
);

	typedef enum logic {stIdle, stRequest} stStateT;

	stStateT state;
	addrT ma;

	// the store table also covers push forms
	agen #(.UNIT(unitStore)) agen0 (
		.inst(inst),
		.a(a),
		.c(c),
		.ma(ma)
	);

	// ==============================
	// control
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stIdle;
			req.valid <= 1'b0;
			done <= 1'b0;
		end else begin
			// done follows the grant by one cycle and lasts one cycle
			done <= 1'b0;
			case (state)
				stIdle: if (go) begin
					state <= stRequest;
					req.valid <= 1'b1;
				end
				default: if (grant) begin
					state <= stIdle;
					req.valid <= 1'b0;
					done <= 1'b1;
				end
			endcase
		end
	end

	// write payload, store data comes from operand b
	always_ff @(posedge clk) begin
		if (state == stIdle && go) begin
			req.write <= 1'b1;
			req.slot <= ma[SLOT_BITS-1:0];
			req.data <= b;
		end
	end

	// busy ends in the grant cycle so a new store may be issued with done
	assign busy = (state != stIdle);

endmodule

`default_nettype wire

// File: src/loadUnit.sv
// Load unit
`timescale 1ns/1ps
`default_nettype none

module loadUnit
	import isaPkg::*, memPkg::*;
(
	input wire clk,
	input wire rst,
	input wire go,
	input wire instT inst,
	input wire wordT a,
	input wire wordT c,
	input wire grant,
	input wire memRspT rsp,
	output memReqT req,
	output logic busy,
	output logic valid,
	output wordT data
);

	typedef enum logic [1:0] {ldIdle, ldRequest, ldWait} ldStateT;

	ldStateT state;
	addrT ma;

	agen #(.UNIT(unitLoad)) agen0 (
		.inst(inst),
		.a(a),
		.c(c),
		.ma(ma)
	);

	// ==============================
	// control
	// ==============================

	// idle accepts a go, request holds until granted, wait catches the read data
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ldIdle;
			req.valid <= 1'b0;
		end else begin
			case (state)
				ldIdle: if (go) begin
					state <= ldRequest;
					req.valid <= 1'b1;
				end
				ldRequest: if (grant) begin
					state <= ldWait;
					req.valid <= 1'b0;
				end
				default: if (rsp.valid) state <= ldIdle;
			endcase
		end
	end

	// request payload is captured once on an accepted go
	always_ff @(posedge clk) begin
		if (state == ldIdle && go) begin
			req.write <= 1'b0;
			req.slot <= ma[SLOT_BITS-1:0];
			req.data <= '0;
		end
	end

	assign busy = (state != ldIdle);

	// the returned word passes straight out in the wait cycle
	assign valid = (state == ldWait) && rsp.valid;
	assign data = rsp.data;

endmodule

`default_nettype wire

// File: src/agen.sv
// Effective address generator
`timescale 1ns/1ps
`default_nettype none

module agen
	import isaPkg::*, memPkg::*;
#(
	parameter unitT UNIT = unitLoad
) (
	input wire instT inst,
	input wire wordT a,
	input wire wordT c,
	output addrT ma
);

	opcodeT opcode;
	wordT cx;
	wordT idxOfs;
	wordT disp;

	assign opcode = inst[opcodeHi:opcodeLo];

	// index offset is unsigned, the displacement is sign extended from bit 39
	assign idxOfs = {72'd0, inst[idxHiMsb:idxHiLsb], inst[idxLoMsb:idxLoLsb]};
	assign disp = {{58{inst[dispSign]}}, inst[dispHiMsb:dispHiLsb], inst[dispLoMsb:dispLoLsb]};

	// scaled index, powers of two are plain shifts
	// the odd factors are built from two shifted copies of c
	always_comb begin
		case (inst[scaleHi:scaleLo])
			3'd0: cx = c;
			3'd1: cx = c << 1;
			3'd2: cx = c << 2;
			3'd3: cx = c << 3;
			3'd4: cx = c << 4;
			3'd5: cx = (c << 2) + c;
			3'd6: cx = (c << 3) + (c << 1);
			default: cx = (c << 4) - c;
		endcase
	end

	// ==============================
	// per unit decode table
	// ==============================

	always_comb begin
		if (UNIT == unitLoad) begin
			// loads only know the indexed form besides displacement
			case (opcode)
				opMLX: ma = a + cx + idxOfs;
				default: ma = a + disp;
			endcase
		end else begin
			// push forms pre-decrement the stack pointer by one word
			case (opcode)
				opPUSH, opPUSHC: ma = a - addrT'(pushSize);
				opMSX: ma = a + cx + idxOfs;
				default: ma = a + disp;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/memPkg.sv
// Memory request and response types
`default_nettype none

package memPkg;

	import isaPkg::*;

	// ==============================
	// address and slot types
	// ==============================

	// full byte address as produced by the address generator
	typedef logic [79:0] addrT;

	// the memory is indexed by the low address bits only
	localparam int SLOT_BITS = 6;
	typedef logic [SLOT_BITS-1:0] slotT;

	// ==============================
	// port structs
	// ==============================

	// what a unit offers to the arbiter and what reaches the memory port
	typedef struct packed {
		logic valid;
		logic write;
		slotT slot;
		wordT data;
	} memReqT;

	// read return from the memory, one cycle after the read
	typedef struct packed {
		logic valid;
		wordT data;
	} memRspT;

	// last grant record kept by the arbiter
	typedef enum logic {ownLoad, ownStore} ownerT;

endpackage

`default_nettype wire

// File: src/isaPkg.sv
// Core instruction set definitions
`default_nettype none

package isaPkg;

	// ==============================
	// data and instruction widths
	// ==============================

	// the core works on 80-bit registers and 40-bit instructions
	typedef logic [79:0] wordT;
	typedef logic [39:0] instT;
	typedef logic [3:0] opcodeT;

	// ==============================
	// instruction field positions
	// ==============================

	// opcode sits in the low nibble of every instruction
	localparam int opcodeHi = 3;
	localparam int opcodeLo = 0;

	// scale select for the indexed forms, picks the index multiplier
	localparam int scaleHi = 30;
	localparam int scaleLo = 28;

	// the 8-bit index offset is split over two pieces of the instruction
	localparam int idxHiMsb = 34;
	localparam int idxHiLsb = 33;
	localparam int idxLoMsb = 21;
	localparam int idxLoLsb = 16;

	// the 22-bit displacement is also split, its sign is the top instruction bit
	localparam int dispHiMsb = 39;
	localparam int dispHiLsb = 33;
	localparam int dispLoMsb = 30;
	localparam int dispLoLsb = 16;
	localparam int dispSign = 39;

	// memory opcodes decoded by the address generator
	localparam opcodeT opLoad = 4'h1;
	localparam opcodeT opMLX = 4'h2;
	localparam opcodeT opStore = 4'h3;
	localparam opcodeT opMSX = 4'h4;
	localparam opcodeT opPUSH = 4'h5;
	localparam opcodeT opPUSHC = 4'h6;

	// which decode table an address generator uses
	typedef enum logic {unitLoad, unitStore} unitT;

	// one word in memory takes ten bytes, which is what a push steps by
	localparam int pushSize = 10;

endpackage

`default_nettype wire
